// File: hdl/mci_pkg.sv
/* Management subsystem definitions */
`default_nettype none

package mci_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////
    localparam int ADDR_W = 24;
    localparam int DATA_W = 32;
    localparam int USER_W = 8;

    //////////////////////////////////////////////////
    // Memory map, byte addresses
    //////////////////////////////////////////////////
    // Register block, 64 words
    localparam logic [ADDR_W-1:0] MCI_REG_START = 24'h00_0000;
    localparam logic [ADDR_W-1:0] MCI_REG_END   = 24'h00_00FF;
    // Trace buffer, 16 entries
    localparam logic [ADDR_W-1:0] TRACE_START   = 24'h01_0000;
    localparam logic [ADDR_W-1:0] TRACE_END     = 24'h01_003F;
    // Mailboxes, 64 words each
    localparam logic [ADDR_W-1:0] MBOX0_START   = 24'h40_0000;
    localparam logic [ADDR_W-1:0] MBOX0_END     = 24'h40_00FF;
    localparam logic [ADDR_W-1:0] MBOX1_START   = 24'h80_0000;
    localparam logic [ADDR_W-1:0] MBOX1_END     = 24'h80_00FF;
    // MCU SRAM, 256 words
    localparam logic [ADDR_W-1:0] SRAM_START    = 24'hC0_0000;
    localparam logic [ADDR_W-1:0] SRAM_END      = 24'hC0_03FF;

    // Target depths in words
    localparam int MBOX_WORDS  = 64;
    localparam int SRAM_WORDS  = 256;
    localparam int TRACE_DEPTH = 16;

    // Extra read wait cycles
    localparam int SRAM_WAIT = 2;
    localparam int MBOX_WAIT = 0;

    //////////////////////////////////////////////////
    // Register word offsets
    //////////////////////////////////////////////////
    localparam int REG_SCRATCH0   = 0;
    localparam int REG_SCRATCH1   = 1;
    localparam int REG_SCRATCH2   = 2;
    localparam int REG_SCRATCH3   = 3;
    localparam int REG_SOC_CONFIG = 4;
    localparam int REG_ID         = 5;

    // Read-only block identification
    localparam logic [DATA_W-1:0] MCI_ID = 32'h4D43_4901;

endpackage

`default_nettype wire

// File: hdl/mci_sub_decode.sv
/* SoC request decoder */
`timescale 1ns/1ns
`default_nettype none

module mci_sub_decode
    import mci_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              arst_n,
    // SoC request
    input  wire logic              dv,
    input  wire logic [ADDR_W-1:0] addr,
    input  wire logic              write,
    input  wire logic [DATA_W-1:0] wdata,
    input  wire logic [USER_W-1:0] user,
    // SoC response
    output logic                   hold,
    output logic      [DATA_W-1:0] rdata,
    output logic                   error,
    // Privileged users
    input  wire logic [USER_W-1:0] strap_soc_config_user,
    input  wire logic [USER_W-1:0] strap_lsu_user,
    input  wire logic [USER_W-1:0] strap_ifu_user,
    output logic                   soc_config_req,
    output logic                   mcu_req,
    // Target requests
    output logic                   reg_sel,
    output logic                   trace_sel,
    output logic                   mbox0_sel,
    output logic                   mbox1_sel,
    output logic                   sram_sel,
    output logic      [ADDR_W-1:0] t_addr,
    output logic                   t_write,
    output logic      [DATA_W-1:0] t_wdata,
    // Target responses
    input  wire logic              reg_hold,
    input  wire logic [DATA_W-1:0] reg_rdata,
    input  wire logic              reg_error,
    input  wire logic              trace_hold,
    input  wire logic [DATA_W-1:0] trace_rdata,
    input  wire logic              trace_error,
    input  wire logic              mbox0_hold,
    input  wire logic [DATA_W-1:0] mbox0_rdata,
    input  wire logic              mbox0_error,
    input  wire logic              mbox1_hold,
    input  wire logic [DATA_W-1:0] mbox1_rdata,
    input  wire logic              mbox1_error,
    input  wire logic              sram_hold,
    input  wire logic [DATA_W-1:0] sram_rdata,
    input  wire logic              sram_error
);

    logic              miss;
    logic [ADDR_W-1:0] base;
    logic              cfg_disable;
    logic              cfg_force;

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////
    assign reg_sel   = dv & (addr inside {[MCI_REG_START:MCI_REG_END]});
    assign trace_sel = dv & (addr inside {[TRACE_START:TRACE_END]});
    assign mbox0_sel = dv & (addr inside {[MBOX0_START:MBOX0_END]});
    assign mbox1_sel = dv & (addr inside {[MBOX1_START:MBOX1_END]});
    assign sram_sel  = dv & (addr inside {[SRAM_START:SRAM_END]});

    // Nothing hit
    assign miss = dv & ~(reg_sel | trace_sel | mbox0_sel | mbox1_sel | sram_sel);

    // Offset inside the selected target
    always_comb begin
        base = '0;
        if (trace_sel) base = TRACE_START;
        if (mbox0_sel) base = MBOX0_START;
        if (mbox1_sel) base = MBOX1_START;
        if (sram_sel)  base = SRAM_START;
    end

    assign t_addr  = addr - base;
    assign t_write = write;
    assign t_wdata = wdata;

    //////////////////////////////////////////////////
    // Response mux
    //////////////////////////////////////////////////
    always_comb begin
        rdata = '0;
        if (reg_sel)   rdata = reg_rdata;
        if (trace_sel) rdata = trace_rdata;
        if (mbox0_sel) rdata = mbox0_rdata;
        if (mbox1_sel) rdata = mbox1_rdata;
        if (sram_sel)  rdata = sram_rdata;
    end

    assign hold  = (reg_sel & reg_hold) | (trace_sel & trace_hold) |
                   (mbox0_sel & mbox0_hold) | (mbox1_sel & mbox1_hold) |
                   (sram_sel & sram_hold);

    // Miss completes at once with error
    assign error = (reg_sel & reg_error) | (trace_sel & trace_error) |
                   (mbox0_sel & mbox0_error) | (mbox1_sel & mbox1_error) |
                   (sram_sel & sram_error) | miss;

    //////////////////////////////////////////////////
    // Privilege detection
    //////////////////////////////////////////////////
    // All zeros: nobody; all ones: everybody
    assign cfg_disable = ~|strap_soc_config_user;
    assign cfg_force   = &strap_soc_config_user;

    assign soc_config_req = dv & (cfg_force |
                            (~cfg_disable & (user == strap_soc_config_user)));

    // LSU or IFU user counts as MCU
    assign mcu_req = dv & ((user == strap_lsu_user) | (user == strap_ifu_user));

    // At most one target per request
    a_sel_mutex: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({reg_sel, trace_sel, mbox0_sel, mbox1_sel, sram_sel}));

    // Ranges ascend without overlap
    if (!(MCI_REG_END < TRACE_START && TRACE_END < MBOX0_START &&
          MBOX0_END < MBOX1_START && MBOX1_END < SRAM_START)) begin : g_map_bad
        $fatal(1, "MCI memory map ranges overlap or are out of order");
    end

endmodule

`default_nettype wire

// File: hdl/mci_reg_block.sv
/* Management registers */
`timescale 1ns/1ns
`default_nettype none

module mci_reg_block
    import mci_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              sel,
    input  wire logic [ADDR_W-1:0] addr,
    input  wire logic              write,
    input  wire logic [DATA_W-1:0] wdata,
    input  wire logic              soc_config_req,
    output logic      [DATA_W-1:0] rdata,
    output logic                   hold,
    output logic                   error,
    output logic      [DATA_W-1:0] soc_config
);

    // Word offset within the 64-word window
    logic [5:0]        idx;
    logic [DATA_W-1:0] scratch [4];
    logic              cfg_denied;
    logic              id_write;
    logic              unused_off;

    assign idx = addr[7:2];

    // Single-cycle target
    assign hold = 1'b0;

    //////////////////////////////////////////////////
    // Access checks
    //////////////////////////////////////////////////
    assign cfg_denied = write & (idx == REG_SOC_CONFIG) & ~soc_config_req;
    assign id_write   = write & (idx == REG_ID);
    assign unused_off = idx > REG_ID;

    assign error = sel & (cfg_denied | id_write | unused_off);

    //////////////////////////////////////////////////
    // Register writes
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scratch    <= '{default: '0};
            soc_config <= '0;
        end else if (sel && write && !error) begin
            if (idx <= REG_SCRATCH3) begin
                scratch[idx[1:0]] <= wdata;
            end
            // Only reached with privilege
            if (idx == REG_SOC_CONFIG) begin
                soc_config <= wdata;
            end
        end
    end

    // Read mux, unused offsets return zero
    always_comb begin
        rdata = '0;
        case (idx)
            REG_SCRATCH0,
            REG_SCRATCH1,
            REG_SCRATCH2,
            REG_SCRATCH3:   rdata = scratch[idx[1:0]];
            REG_SOC_CONFIG: rdata = soc_config;
            REG_ID:         rdata = MCI_ID;
            default:        rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/mci_mem_target.sv
/* Word memory target */
`timescale 1ns/1ns
`default_nettype none

module mci_mem_target
    import mci_pkg::*;
#(
    parameter int DEPTH   = 64,
    parameter int WAIT    = 0,
    parameter bit PROTECT = 1'b0
) (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              sel,
    input  wire logic [ADDR_W-1:0] addr,
    input  wire logic              write,
    input  wire logic [DATA_W-1:0] wdata,
    input  wire logic              wr_allowed,
    output logic      [DATA_W-1:0] rdata,
    output logic                   hold,
    output logic                   error
);

    localparam int AW = $clog2(DEPTH);
    // Counts up to WAIT+1
    localparam int CW = $clog2(WAIT + 2);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [AW-1:0]     idx;
    logic [CW-1:0]     wait_cnt;
    logic              rd_req;

    assign idx    = addr[AW+1:2];
    assign rd_req = sel & ~write;

    //////////////////////////////////////////////////
    // Read wait states
    //////////////////////////////////////////////////
    // Hold for WAIT+1 cycles, release on the next
    assign hold = rd_req & (wait_cnt <= CW'(WAIT));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
        end else if (rd_req && hold) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // Protected write without privilege
    assign error = PROTECT & sel & write & ~wr_allowed;

    //////////////////////////////////////////////////
    // Array
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (sel && write && !error) begin
            mem[idx] <= wdata;
        end
        // Registered read, valid once hold drops
        if (rd_req) begin
            rdata <= mem[idx];
        end
    end

    // Requester keeps the address steady while held
    a_addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (sel && hold) |=> $stable(addr));

endmodule

`default_nettype wire

// File: hdl/mci_trace_buffer.sv
/* Trace ring buffer */
`timescale 1ns/1ns
`default_nettype none

module mci_trace_buffer
    import mci_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              arst_n,
    // Trace port
    input  wire logic              trace_valid,
    input  wire logic [DATA_W-1:0] trace_data,
    // SoC side, read only
    input  wire logic              sel,
    input  wire logic [ADDR_W-1:0] addr,
    input  wire logic              write,
    output logic      [DATA_W-1:0] rdata,
    output logic                   hold,
    output logic                   error
);

    localparam int PW = $clog2(TRACE_DEPTH);

    logic [DATA_W-1:0] ring [TRACE_DEPTH];
    logic [PW-1:0]     wr_ptr;
    logic [PW:0]       count;
    logic [PW-1:0]     idx;
    logic [PW-1:0]     rd_pos;
    logic              filled;

    //////////////////////////////////////////////////
    // Fill side
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            count  <= '0;
        end else if (trace_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
            // Saturates once full
            if (count != (PW+1)'(TRACE_DEPTH)) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (trace_valid) begin
            ring[wr_ptr] <= trace_data;
        end
    end

    //////////////////////////////////////////////////
    // SoC read side
    //////////////////////////////////////////////////
    assign idx = addr[PW+1:2];

    // Entry 0 is the newest word
    assign rd_pos = wr_ptr - idx - 1'b1;
    assign filled = {1'b0, idx} < count;

    assign rdata = filled ? ring[rd_pos] : '0;
    assign hold  = 1'b0;

    // No SoC writes
    assign error = sel & write;

endmodule

`default_nettype wire

// File: hdl/mci_top.sv
/* Management subsystem top */
`timescale 1ns/1ns
`default_nettype none

module mci_top
    import mci_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              arst_n,
    // SoC request and response
    input  wire logic              dv,
    input  wire logic [ADDR_W-1:0] addr,
    input  wire logic              write,
    input  wire logic [DATA_W-1:0] wdata,
    input  wire logic [USER_W-1:0] user,
    output logic                   hold,
    output logic      [DATA_W-1:0] rdata,
    output logic                   error,
    // Straps
    input  wire logic [USER_W-1:0] strap_soc_config_user,
    input  wire logic [USER_W-1:0] strap_lsu_user,
    input  wire logic [USER_W-1:0] strap_ifu_user,
    // Trace port
    input  wire logic              trace_valid,
    input  wire logic [DATA_W-1:0] trace_data,
    // Status
    output logic                   mcu_req,
    output logic                   soc_config_req,
    output logic      [DATA_W-1:0] soc_config
);

    // Shared target request
    logic              reg_sel, trace_sel, mbox0_sel, mbox1_sel, sram_sel;
    logic [ADDR_W-1:0] t_addr;
    logic              t_write;
    logic [DATA_W-1:0] t_wdata;

    // Target responses
    logic              reg_hold, trace_hold, mbox0_hold, mbox1_hold, sram_hold;
    logic              reg_error, trace_error, mbox0_error, mbox1_error, sram_error;
    logic [DATA_W-1:0] reg_rdata, trace_rdata, mbox0_rdata, mbox1_rdata, sram_rdata;

    mci_sub_decode u_decode (
        .clk, .arst_n,
        .dv, .addr, .write, .wdata, .user,
        .hold, .rdata, .error,
        .strap_soc_config_user, .strap_lsu_user, .strap_ifu_user,
        .soc_config_req, .mcu_req,
        .reg_sel, .trace_sel, .mbox0_sel, .mbox1_sel, .sram_sel,
        .t_addr, .t_write, .t_wdata,
        .reg_hold, .reg_rdata, .reg_error,
        .trace_hold, .trace_rdata, .trace_error,
        .mbox0_hold, .mbox0_rdata, .mbox0_error,
        .mbox1_hold, .mbox1_rdata, .mbox1_error,
        .sram_hold, .sram_rdata, .sram_error
    );

    mci_reg_block u_regs (
        .clk, .arst_n,
        .sel (reg_sel), .addr (t_addr), .write (t_write), .wdata (t_wdata),
        .soc_config_req,
        .rdata (reg_rdata), .hold (reg_hold), .error (reg_error),
        .soc_config
    );

    mci_trace_buffer u_trace (
        .clk, .arst_n,
        .trace_valid, .trace_data,
        .sel (trace_sel), .addr (t_addr), .write (t_write),
        .rdata (trace_rdata), .hold (trace_hold), .error (trace_error)
    );

    //////////////////////////////////////////////////
    // Memories
    //////////////////////////////////////////////////
    // Mailboxes open to any user
    mci_mem_target #(.DEPTH(MBOX_WORDS), .WAIT(MBOX_WAIT), .PROTECT(1'b0)) u_mbox0 (
        .clk, .arst_n,
        .sel (mbox0_sel), .addr (t_addr), .write (t_write), .wdata (t_wdata),
        .wr_allowed (1'b1),
        .rdata (mbox0_rdata), .hold (mbox0_hold), .error (mbox0_error)
    );

    mci_mem_target #(.DEPTH(MBOX_WORDS), .WAIT(MBOX_WAIT), .PROTECT(1'b0)) u_mbox1 (
        .clk, .arst_n,
        .sel (mbox1_sel), .addr (t_addr), .write (t_write), .wdata (t_wdata),
        .wr_allowed (1'b1),
        .rdata (mbox1_rdata), .hold (mbox1_hold), .error (mbox1_error)
    );

    // SRAM writes only from MCU users
    mci_mem_target #(.DEPTH(SRAM_WORDS), .WAIT(SRAM_WAIT), .PROTECT(1'b1)) u_sram (
        .clk, .arst_n,
        .sel (sram_sel), .addr (t_addr), .write (t_write), .wdata (t_wdata),
        .wr_allowed (mcu_req),
        .rdata (sram_rdata), .hold (sram_hold), .error (sram_error)
    );

endmodule

`default_nettype wire

// File: tb/mci_tb.sv
/* Management subsystem testbench */
`timescale 1ns/1ns
`default_nettype none

module mci_tb
    import mci_pkg::*;
();

    logic              clk;
    logic              arst_n;
    logic              dv;
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic [DATA_W-1:0] wdata;
    logic [USER_W-1:0] user;
    logic              hold;
    logic [DATA_W-1:0] rdata;
    logic              error;
    logic [USER_W-1:0] strap_soc_config_user;
    logic [USER_W-1:0] strap_lsu_user;
    logic [USER_W-1:0] strap_ifu_user;
    logic              trace_valid;
    logic [DATA_W-1:0] trace_data;
    logic              mcu_req;
    logic              soc_config_req;
    logic [DATA_W-1:0] soc_config;

    // Reference models
    logic [DATA_W-1:0] mbox0_model [MBOX_WORDS];
    logic [DATA_W-1:0] mbox1_model [MBOX_WORDS];
    logic [DATA_W-1:0] sram_model [SRAM_WORDS];
    logic [DATA_W-1:0] trace_q [$];

    // Last completed response
    logic [DATA_W-1:0] rsp_rdata;
    logic              rsp_error;
    logic              rsp_mcu;
    logic              rsp_cfg;
    int                rsp_held;

    int          checks;
    int          errors;
    int          timeouts;
    logic [31:0] rng_state;

    mci_top dut0 (.*);

    // 4 ns clock
    always #2 clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    // Drive one request and sample mid low phase until hold drops
    task automatic access(input logic [ADDR_W-1:0] a, input logic wr,
                          input logic [DATA_W-1:0] d, input logic [USER_W-1:0] u);
        int cycles;
        cycles = 0;
        @(negedge clk);
        dv    = 1'b1;
        addr  = a;
        write = wr;
        wdata = d;
        user  = u;
        #1;
        while (hold && cycles < 20) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (hold) begin
            timeouts++;
            $display("Timeout: hold still high after 20 cycles at address %h", a);
        end
        rsp_rdata = rdata;
        rsp_error = error;
        rsp_mcu   = mcu_req;
        rsp_cfg   = soc_config_req;
        rsp_held  = cycles;
        // Transfer commits on the posedge in between
        @(negedge clk);
        dv    = 1'b0;
        write = 1'b0;
    endtask

    // Newest word at the queue front
    task automatic push_trace(input logic [DATA_W-1:0] d);
        @(negedge clk);
        trace_valid = 1'b1;
        trace_data  = d;
        trace_q.push_front(d);
        @(negedge clk);
        trace_valid = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////
    task automatic run_reg_block();
        logic [DATA_W-1:0] val [4];
        logic [DATA_W-1:0] cfg;
        for (int i = 0; i < 4; i++) begin
            val[i] = next_rand();
            access(MCI_REG_START + 4 * i, 1'b1, val[i], 8'h00);
            check_value("scratch_wr_error", rsp_error, 0);
        end
        for (int i = 0; i < 4; i++) begin
            access(MCI_REG_START + 4 * i, 1'b0, '0, 8'h00);
            check_value("scratch_rdata", rsp_rdata, val[i]);
        end
        // Read-only ID
        access(MCI_REG_START + 4 * REG_ID, 1'b0, '0, 8'h00);
        check_value("id_rdata", rsp_rdata, MCI_ID);
        access(MCI_REG_START + 4 * REG_ID, 1'b1, 32'h1234_5678, 8'h11);
        check_value("id_wr_error", rsp_error, 1);
        check_value("soc_config_req_id", rsp_cfg, 1);
        // Privileged config write
        cfg = next_rand();
        access(MCI_REG_START + 4 * REG_SOC_CONFIG, 1'b1, cfg, 8'h11);
        check_value("cfg_wr_error", rsp_error, 0);
        check_value("soc_config_req_priv", rsp_cfg, 1);
        access(MCI_REG_START + 4 * REG_SOC_CONFIG, 1'b0, '0, 8'h00);
        check_value("cfg_rdata", rsp_rdata, cfg);
        check_value("soc_config", soc_config, cfg);
        // Unprivileged user is refused
        access(MCI_REG_START + 4 * REG_SOC_CONFIG, 1'b1, ~cfg, 8'h44);
        check_value("cfg_denied_error", rsp_error, 1);
        check_value("soc_config_req_other", rsp_cfg, 0);
        access(MCI_REG_START + 4 * REG_SOC_CONFIG, 1'b0, '0, 8'h00);
        check_value("cfg_kept_rdata", rsp_rdata, cfg);
        check_value("soc_config_kept", soc_config, cfg);
    endtask

    task automatic mailbox_readback();
        int idx [$];
        int k;
        for (int i = 0; i < 8; i++) begin
            k = next_rand() % MBOX_WORDS;
            idx.push_back(k);
            // Same index in both with different data
            mbox0_model[k] = next_rand();
            mbox1_model[k] = next_rand();
            access(MBOX0_START + 4 * k, 1'b1, mbox0_model[k], 8'h00);
            check_value("mbox0_wr_error", rsp_error, 0);
            access(MBOX1_START + 4 * k, 1'b1, mbox1_model[k], 8'h00);
            check_value("mbox1_wr_error", rsp_error, 0);
        end
        foreach (idx[i]) begin
            access(MBOX0_START + 4 * idx[i], 1'b0, '0, 8'h00);
            check_value("mbox0_rdata", rsp_rdata, mbox0_model[idx[i]]);
            access(MBOX1_START + 4 * idx[i], 1'b0, '0, 8'h00);
            check_value("mbox1_rdata", rsp_rdata, mbox1_model[idx[i]]);
        end
    endtask

    task automatic sram_protection();
        int a;
        int b;
        a = next_rand() % SRAM_WORDS;
        b = (a + 1) % SRAM_WORDS;
        // LSU and IFU users may write
        sram_model[a] = next_rand();
        access(SRAM_START + 4 * a, 1'b1, sram_model[a], 8'h22);
        check_value("sram_lsu_error", rsp_error, 0);
        check_value("mcu_req_lsu", rsp_mcu, 1);
        sram_model[b] = next_rand();
        access(SRAM_START + 4 * b, 1'b1, sram_model[b], 8'h33);
        check_value("sram_ifu_error", rsp_error, 0);
        check_value("mcu_req_ifu", rsp_mcu, 1);
        access(SRAM_START + 4 * a, 1'b0, '0, 8'h00);
        check_value("sram_rdata_a", rsp_rdata, sram_model[a]);
        access(SRAM_START + 4 * b, 1'b0, '0, 8'h00);
        check_value("sram_rdata_b", rsp_rdata, sram_model[b]);
        // Other user is refused and the old value stays
        access(SRAM_START + 4 * a, 1'b1, ~sram_model[a], 8'h44);
        check_value("sram_denied_error", rsp_error, 1);
        check_value("mcu_req_other", rsp_mcu, 0);
        access(SRAM_START + 4 * a, 1'b0, '0, 8'h00);
        check_value("sram_kept_rdata", rsp_rdata, sram_model[a]);
    endtask

    task automatic decode_misses();
        logic [ADDR_W-1:0] miss_addr [3];
        miss_addr = '{24'h00_0100, 24'h02_0000, 24'hC0_0400};
        foreach (miss_addr[i]) begin
            access(miss_addr[i], 1'b0, '0, 8'h00);
            check_value("miss_error", rsp_error, 1);
            check_value("miss_rdata", rsp_rdata, 0);
        end
    endtask

    task automatic trace_ring();
        logic [DATA_W-1:0] fifth;
        for (int i = 0; i < 5; i++) begin
            push_trace(next_rand());
        end
        fifth = trace_q[0];
        for (int i = 0; i < 5; i++) begin
            access(TRACE_START + 4 * i, 1'b0, '0, 8'h00);
            check_value("trace_rdata", rsp_rdata, trace_q[i]);
        end
        // Not yet filled
        access(TRACE_START + 4 * 5, 1'b0, '0, 8'h00);
        check_value("trace_empty_rdata", rsp_rdata, 0);
        access(TRACE_START, 1'b1, 32'hDEAD_BEEF, 8'h00);
        check_value("trace_wr_error", rsp_error, 1);
        // Wrap around with 20 pushes in total
        for (int i = 0; i < 15; i++) begin
            push_trace(next_rand());
        end
        access(TRACE_START + 4 * 15, 1'b0, '0, 8'h00);
        check_value("trace_oldest_rdata", rsp_rdata, fifth);
    endtask

    task automatic sram_hold();
        int k;
        k = next_rand() % SRAM_WORDS;
        sram_model[k] = next_rand();
        access(SRAM_START + 4 * k, 1'b1, sram_model[k], 8'h22);
        access(SRAM_START + 4 * k, 1'b0, '0, 8'h00);
        check_value("sram_read_held", rsp_held != 0, 1);
        check_value("sram_hold_rdata", rsp_rdata, sram_model[k]);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        clk                   = 1'b0;
        arst_n                = 1'b0;
        dv                    = 1'b0;
        addr                  = '0;
        write                 = 1'b0;
        wdata                 = '0;
        user                  = '0;
        strap_soc_config_user = 8'h11;
        strap_lsu_user        = 8'h22;
        strap_ifu_user        = 8'h33;
        trace_valid           = 1'b0;
        trace_data            = '0;
        checks                = 0;
        errors                = 0;
        timeouts              = 0;
        rng_state             = 32'd84;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        #1;
        // Idle outputs after reset
        check_value("reset_hold", hold, 0);
        check_value("reset_error", error, 0);
        check_value("reset_mcu_req", mcu_req, 0);
        check_value("reset_soc_config_req", soc_config_req, 0);
        run_reg_block();
        mailbox_readback();
        sram_protection();
        decode_misses();
        trace_ring();
        sram_hold();
        $display("Summary: %0d checks, %0d value errors, %0d timeouts",
                 checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
hdl/mci_pkg.sv
hdl/mci_sub_decode.sv
hdl/mci_reg_block.sv
hdl/mci_mem_target.sv
hdl/mci_trace_buffer.sv
hdl/mci_top.sv
tb/mci_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the MCI testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module mci_tb \
    -f list.f -o mci_sim || { echo "Build failed"; exit 1; }
out=$(./obj_dir/mci_sim)
echo "$out"
echo "$out" | grep -qx '>>> PASS' && echo "Result: passed" \
    || { echo "Result: failed"; exit 1; }
